//--- fetch_pkg.sv
package fetch_pkg;

	localparam int ADDR_W    = 32;
	localparam int WORD_W    = 32;
	localparam int MEM_WORDS = 256;
	localparam int MEM_AW    = $clog2(MEM_WORDS);	// word index bits

	typedef logic [ADDR_W-1:0] addr_t;	// byte address
	typedef logic [WORD_W-1:0] word_t;	// instruction or data word
	typedef logic [MEM_AW-1:0] mem_idx_t;

	// first fetched address
	localparam addr_t RESET_PC = 32'h0000_0100;

	// apb request, master to slave
	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		addr_t paddr;
		word_t pwdata;
	} apb_req_t;

	// apb response, slave to master
	typedef struct packed {
		logic  pready;
		word_t prdata;
	} apb_rsp_t;

	// one fetch record for decode
	typedef struct packed {
		addr_t pc;
		word_t inst;
		logic  adel;	// address error on fetch
	} fetch_out_t;

endpackage

//--- fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall_i,
	input  logic                  branch_i,
	input  fetch_pkg::addr_t      branch_pc_i,
	input  logic                  flush_i,
	input  fetch_pkg::addr_t      flush_pc_i,
	output fetch_pkg::apb_req_t   bus_req_o,
	input  fetch_pkg::apb_rsp_t   bus_rsp_i,
	output logic                  fetch_valid_o,
	output fetch_pkg::fetch_out_t fetch_o
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_t;

	state_t state_q;
	addr_t  pc_q;	// in-flight fetch, or the next one when idle

	// redirects that arrived while a fetch was on the bus
	addr_t  flush_hold_q;
	logic   flush_use_q;
	addr_t  branch_hold_q;
	logic   branch_use_q;

	logic   done;
	logic   decide;
	logic   flush_pend;
	logic   branch_pend;
	logic   redir_pend;
	addr_t  flush_tgt;
	addr_t  branch_tgt;
	addr_t  redir_tgt;
	addr_t  cand_pc;
	logic   cand_bad;

	assign done   = (state_q == ST_ACCESS) && bus_rsp_i.pready;
	assign decide = (state_q == ST_IDLE) || done;	// next address is chosen here

	// live pulse overrides the stored copy
	assign flush_pend  = flush_i | flush_use_q;
	assign flush_tgt   = flush_i ? flush_pc_i : flush_hold_q;
	assign branch_pend = branch_i | branch_use_q;
	assign branch_tgt  = branch_i ? branch_pc_i : branch_hold_q;
	assign redir_pend  = flush_pend | branch_pend;
	assign redir_tgt   = flush_pend ? flush_tgt : branch_tgt;	// flush wins

	always_comb begin
		if (redir_pend)
			cand_pc = redir_tgt;
		else if (state_q == ST_IDLE)
			cand_pc = pc_q;
		else
			cand_pc = pc_q + 32'd4;
	end

	assign cand_bad = |cand_pc[1:0];

	always_comb begin
		bus_req_o         = '0;	// read only master
		bus_req_o.psel    = (state_q != ST_IDLE);
		bus_req_o.penable = (state_q == ST_ACCESS);
		bus_req_o.paddr   = pc_q;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			pc_q    <= RESET_PC;
		end else if (state_q == ST_SETUP) begin
			state_q <= ST_ACCESS;
		end else if (decide) begin
			if (stall_i) begin
				state_q <= ST_IDLE;
				pc_q    <= cand_pc;
			end else if (cand_bad) begin
				// reported from idle, then stepped over
				state_q <= ST_IDLE;
				pc_q    <= (state_q == ST_IDLE) ? cand_pc + 32'd4 : cand_pc;
			end else begin
				state_q <= ST_SETUP;	// back to back fetch
				pc_q    <= cand_pc;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_use_q  <= 1'b0;
			branch_use_q <= 1'b0;
		end else if (decide) begin
			flush_use_q  <= 1'b0;	// consumed by the next address
			branch_use_q <= 1'b0;
		end else begin
			if (flush_i)
				flush_use_q <= 1'b1;
			if (branch_i)
				branch_use_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!decide && flush_i)
			flush_hold_q <= flush_pc_i;
		if (!decide && branch_i)
			branch_hold_q <= branch_pc_i;	// a later branch replaces it
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_valid_o <= 1'b0;
			fetch_o       <= '0;
		end else begin
			fetch_valid_o <= 1'b0;
			if (done && !redir_pend) begin
				fetch_valid_o <= 1'b1;
				fetch_o.pc    <= pc_q;
				fetch_o.inst  <= bus_rsp_i.prdata;
				fetch_o.adel  <= 1'b0;
			end else if ((state_q == ST_IDLE) && !stall_i && cand_bad) begin
				fetch_valid_o <= 1'b1;	// exception record, no bus access
				fetch_o.pc    <= cand_pc;
				fetch_o.inst  <= '0;
				fetch_o.adel  <= 1'b1;
			end
		end
	end

	// address held through wait states
	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bus_req_o.penable && !bus_rsp_i.pready |=> $stable(bus_req_o.paddr))
		else $error("fetch paddr changed during access phase");

	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		bus_req_o.psel |-> (bus_req_o.paddr[1:0] == 2'b00))
		else $error("misaligned fetch address on bus");

endmodule

//--- fetch_mem_arb.sv
`timescale 1ns/1ps

module fetch_mem_arb (
	input  logic                clk,
	input  logic                rst_n,
	input  fetch_pkg::apb_req_t fetch_req_i,
	output fetch_pkg::apb_rsp_t fetch_rsp_o,
	input  fetch_pkg::apb_req_t load_req_i,
	output fetch_pkg::apb_rsp_t load_rsp_o,
	output fetch_pkg::apb_req_t mem_req_o,
	input  fetch_pkg::apb_rsp_t mem_rsp_i
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_FETCH,
		OWN_LOAD
	} owner_t;

	owner_t owner_q;
	owner_t sel;	// owner seen by this cycle

	// grant only while idle with the load port first
	always_comb begin
		sel = owner_q;
		if (owner_q == OWN_NONE) begin
			if (load_req_i.psel)
				sel = OWN_LOAD;
			else if (fetch_req_i.psel)
				sel = OWN_FETCH;
		end
	end

	always_comb begin
		case (sel)
			OWN_FETCH: mem_req_o = fetch_req_i;
			OWN_LOAD:  mem_req_o = load_req_i;
			default:   mem_req_o = '0;
		endcase
		// a master that waited is already in access, so the memory
		// still gets its setup cycle on the grant
		if (owner_q == OWN_NONE)
			mem_req_o.penable = 1'b0;
	end

	always_comb begin
		fetch_rsp_o = '0;
		load_rsp_o  = '0;
		if (sel == OWN_FETCH)
			fetch_rsp_o = mem_rsp_i;
		if (sel == OWN_LOAD)
			load_rsp_o = mem_rsp_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			owner_q <= OWN_NONE;
		else if (owner_q == OWN_NONE)
			owner_q <= sel;	// setup phase seen
		else if (mem_rsp_i.pready)
			owner_q <= OWN_NONE;	// transfer ends
	end

	// the owner stays in its access phase until pready
	a_owner_active: assert property (@(posedge clk) disable iff (!rst_n)
		(owner_q != OWN_NONE) |-> (mem_req_o.psel && mem_req_o.penable))
		else $error("bus owner dropped its transfer before pready");

	a_owner_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(owner_q != OWN_NONE) && !mem_rsp_i.pready |=> $stable(mem_req_o))
		else $error("memory request changed during a transfer");

endmodule

//--- inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
	input  logic                clk,
	input  logic                rst_n,
	input  fetch_pkg::apb_req_t req_i,
	output fetch_pkg::apb_rsp_t rsp_o
);
	import fetch_pkg::*;

	word_t    mem_q [MEM_WORDS];
	word_t    rdata_q;
	logic     wait_q;	// read already spent its wait cycle
	mem_idx_t idx;
	logic     access;
	logic     rd_first;

	assign idx      = req_i.paddr[MEM_AW+1:2];	// word index
	assign access   = req_i.psel && req_i.penable;
	assign rd_first = access && !req_i.pwrite && !wait_q;

	// write lands on the first access cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem_q[i] <= '0;
		end else if (access && req_i.pwrite) begin
			mem_q[idx] <= req_i.pwdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_q <= 1'b0;
		else
			wait_q <= rd_first;	// drops again with pready
	end

	always_ff @(posedge clk) begin
		if (rd_first)
			rdata_q <= mem_q[idx];
	end

	always_comb begin
		rsp_o.pready = access && (req_i.pwrite || wait_q);
		rsp_o.prdata = rdata_q;
	end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall_i,
	input  logic                  branch_i,
	input  fetch_pkg::addr_t      branch_pc_i,
	input  logic                  flush_i,
	input  fetch_pkg::addr_t      flush_pc_i,
	input  fetch_pkg::apb_req_t   load_req_i,
	output fetch_pkg::apb_rsp_t   load_rsp_o,
	output logic                  fetch_valid_o,
	output fetch_pkg::fetch_out_t fetch_o
);
	import fetch_pkg::*;

	apb_req_t fetch_req;	// fetch stage to arbiter
	apb_rsp_t fetch_rsp;
	apb_req_t mem_req;	// arbiter to memory
	apb_rsp_t mem_rsp;

	fetch_pc fetch_pc_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall_i),
		.branch_i      (branch_i),
		.branch_pc_i   (branch_pc_i),
		.flush_i       (flush_i),
		.flush_pc_i    (flush_pc_i),
		.bus_req_o     (fetch_req),
		.bus_rsp_i     (fetch_rsp),
		.fetch_valid_o (fetch_valid_o),
		.fetch_o       (fetch_o)
	);

	fetch_mem_arb fetch_mem_arb_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req_i (fetch_req),
		.fetch_rsp_o (fetch_rsp),
		.load_req_i  (load_req_i),
		.load_rsp_o  (load_rsp_o),
		.mem_req_o   (mem_req),
		.mem_rsp_i   (mem_rsp)
	);

	inst_mem inst_mem_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.req_i (mem_req),
		.rsp_o (mem_rsp)
	);

endmodule

//--- fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int CLK_HALF   = 4;
	localparam int LINE_CYCLES = 40;	// watchdog budget per stimulus line

	logic       clk;
	logic       rst_n;
	logic       stall_i;
	logic       branch_i;
	addr_t      branch_pc_i;
	logic       flush_i;
	addr_t      flush_pc_i;
	apb_req_t   load_req_i;
	apb_rsp_t   load_rsp_o;
	logic       fetch_valid_o;
	fetch_out_t fetch_o;

	fetch_out_t exp_q[$];	// expected records with the oldest first
	word_t      model_mem [MEM_WORDS];
	int         seen_cnt;
	int         wait_target;
	int         lines_total;

	fetch_top fetch_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall_i),
		.branch_i      (branch_i),
		.branch_pc_i   (branch_pc_i),
		.flush_i       (flush_i),
		.flush_pc_i    (flush_pc_i),
		.load_req_i    (load_req_i),
		.load_rsp_o    (load_rsp_o),
		.fetch_valid_o (fetch_valid_o),
		.fetch_o       (fetch_o)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic error_stop(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped on error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			error_stop("value check failed");
		end
	endtask

	// compare one record against the queue and the model memory
	task automatic check_record();
		fetch_out_t rec;
		if (fetch_valid_o) begin
			if (exp_q.size() == 0) begin
				error_stop($sformatf("fetch record for pc %h arrived with none expected",
					fetch_o.pc));
			end else begin
				rec = exp_q.pop_front();
				check_val("fetch_o.pc", fetch_o.pc, rec.pc);
				check_val("fetch_o.inst", fetch_o.inst, rec.inst);
				check_val("fetch_o.adel", {31'd0, fetch_o.adel}, {31'd0, rec.adel});
				if (!rec.adel)
					check_val("model inst", fetch_o.inst, model_mem[rec.pc[MEM_AW+1:2]]);
				seen_cnt++;
			end
		end
	endtask

	task automatic tick();
		@(negedge clk);
		check_record();
	endtask

	// apb write on the load port that waits for pready
	task automatic load_word(input addr_t addr, input word_t data);
		load_req_i.psel    = 1'b1;
		load_req_i.penable = 1'b0;
		load_req_i.pwrite  = 1'b1;
		load_req_i.paddr   = addr;
		load_req_i.pwdata  = data;
		tick();
		load_req_i.penable = 1'b1;
		#1;
		while (!load_rsp_o.pready) begin
			tick();
			#1;
		end
		tick();	// transfer ends on that edge
		load_req_i = '0;
		model_mem[addr[MEM_AW+1:2]] = data;
	endtask

	task automatic redirect(input logic do_flush, input addr_t fpc,
		input logic do_branch, input addr_t bpc);
		flush_i     = do_flush;
		flush_pc_i  = fpc;
		branch_i    = do_branch;
		branch_pc_i = bpc;
		tick();
		flush_i  = 1'b0;
		branch_i = 1'b0;
	endtask

	task automatic count_lines();
		int    fd;
		string line;
		fd = $fopen("fetch_stimulus.txt", "r");
		if (fd == 0) begin
			error_stop("cannot open fetch_stimulus.txt");
		end else begin
			while ($fgets(line, fd))
				lines_total++;
			$fclose(fd);
		end
	endtask

	task automatic run_stimulus();
		int          fd;
		string       line;
		byte         cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fetch_out_t  rec;
		fd = $fopen("fetch_stimulus.txt", "r");
		while ($fgets(line, fd)) begin
			if (line.len() < 2)
				continue;
			cmd = line.getc(0);
			if (cmd == "#")
				continue;
			a = '0;
			b = '0;
			c = '0;
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
			case (cmd)
				"L": load_word(a, b);
				"B": redirect(1'b0, '0, 1'b1, a);
				"F": redirect(1'b1, a, 1'b0, '0);
				"D": redirect(1'b1, a, 1'b1, b);	// flush and branch together
				"S": stall_i = a[0];
				"C": repeat (a) tick();
				"E": begin
					rec.pc   = a;
					rec.inst = b;
					rec.adel = c[0];
					exp_q.push_back(rec);
				end
				"W": begin
					wait_target += a;
					while (seen_cnt < wait_target)
						tick();
				end
				default: error_stop($sformatf("unknown stimulus command: %s", line));
			endcase
		end
		$fclose(fd);
	endtask

	initial begin
		rst_n       = 1'b0;
		stall_i     = 1'b1;	// no fetching until the program is loaded
		branch_i    = 1'b0;
		branch_pc_i = '0;
		flush_i     = 1'b0;
		flush_pc_i  = '0;
		load_req_i  = '0;
		seen_cnt    = 0;
		wait_target = 0;
		lines_total = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		count_lines();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		run_stimulus();
		if (exp_q.size() != 0) begin
			$display("%0d expected fetch records never appeared", exp_q.size());
			$display("** FAIL **");
			$fatal(1, "missing fetch records");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

	initial begin
		wait (lines_total != 0);
		repeat (lines_total * LINE_CYCLES) @(posedge clk);
		error_stop("timeout: stimulus did not finish in time");
	end

endmodule

//--- fetch_stimulus.txt
# L addr data | B addr | F addr | D flush_addr branch_addr | S stall | C cycles
# E pc inst adel (expected record) | W records to wait for
L 100 11110000
L 104 22220004
L 108 33330008
L 10c 4444000c
L 110 55550010
L 114 66660014
L 118 77770018
L 11c 8888001c
L 200 b0000200
L 204 b0000204
L 300 f0000300
L 304 f0000304
E 100 11110000 0
E 104 22220004 0
E 108 33330008 0
E 10c 4444000c 0
S 0
W 4
E 200 b0000200 0
E 204 b0000204 0
B 200
W 2
E 300 f0000300 0
E 304 f0000304 0
D 300 200
W 2
E 100 11110000 0
E 104 22220004 0
B 200
F 100
W 2
E 202 00000000 1
B 202
W 1
E 110 55550010 0
E 114 66660014 0
F 110
W 2
E 118 77770018 0
S 1
W 1
C 10
E 11c 8888001c 0
E 120 00000000 0
S 0
W 2
E 124 00000000 0
E 128 abcd1234 0
E 12c 00000000 0
L 128 abcd1234
W 3
E 130 00000000 0
S 1
W 1
C 5

//--- build.f
fetch_pkg.sv
fetch_pc.sv
fetch_mem_arb.sv
inst_mem.sv
fetch_top.sv
fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
